/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import mips_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [4:0]      shamt,
    input  alu_op_t         op,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    // Signed compare for SLT and SLTI
    logic less;

    assign less = $signed(a) < $signed(b);

    //////////////////////////////
    // Operation select
    //////////////////////////////
    always_comb
    begin
        case (op)
            // Add and subtract wrap, no overflow trap
            ALU_ADD:
                result = a + b;
            ALU_SUB:
                result = a - b;
            ALU_AND:
                result = a & b;
            ALU_OR:
                result = a | b;
            ALU_NOR:
                result = ~(a | b);
            ALU_XOR:
                result = a ^ b;
            ALU_SLT:
                result = {{(XLEN-1){1'b0}}, less};
            // Shift applies to the rt operand
            ALU_SLL:
                result = b << shamt;
            default:
                result = '0;
        endcase
    end

    // Equal operands give zero after subtract, used by BEQ
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* hw/core_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl import mips_pkg::*; #(
    parameter int  IMEM_WORDS = 64,
    parameter int  DMEM_WORDS = 64,
    localparam int IMEM_AW    = (IMEM_WORDS > 1) ? $clog2(IMEM_WORDS) : 1,
    localparam int DMEM_AW    = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1
) (
    input  logic               i_clk,
    input  logic               rst,
    input  logic               start,
    // Instruction memory
    output logic [IMEM_AW-1:0] imem_addr,
    input  instr_t             imem_instr,
    // Data memory
    output logic [DMEM_AW-1:0] dmem_addr,
    output logic [XLEN-1:0]    dmem_wdata,
    output logic               dmem_we,
    input  logic [XLEN-1:0]    dmem_rdata,
    // ALU
    output logic [XLEN-1:0]    alu_a,
    output logic [XLEN-1:0]    alu_b,
    output logic [4:0]         alu_shamt,
    output alu_op_t            alu_op,
    input  logic [XLEN-1:0]    alu_result,
    input  logic               alu_zero,
    regfile_if.ctrl            rf,
    // Retire report
    output logic               retire,
    output logic [XLEN-1:0]    retire_pc,
    output logic               retire_we,
    output logic [XLEN-1:0]    retire_waddr,
    output logic [XLEN-1:0]    retire_wdata,
    output logic               halted,
    // Program load allowed
    output logic               idle
);

    typedef enum logic [2:0] {
        S_IDLE      = 3'd0,
        S_FETCH     = 3'd1,
        S_DECODE    = 3'd2,
        S_EXECUTE   = 3'd3,
        S_MEM       = 3'd4,
        S_WRITEBACK = 3'd5,
        S_HALT      = 3'd6
    } state_t;

    state_t state, state_nxt;
    logic [XLEN-1:0] pc;

    // Per-instruction registers
    instr_t          ir;
    logic [XLEN-1:0] rs_val, rt_val, alu_out;
    logic            zero_q;

    // Decode results
    logic                  writes_reg, use_imm, imm_zext;
    logic                  is_lw, is_sw, is_beq, is_halt;
    logic [REG_ADDR_W-1:0] dest;
    logic [XLEN-1:0]       imm_ext, pc_plus4, next_pc, wb_data;

    //////////////////////////////
    // State and PC
    //////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (rst)
        begin
            state <= S_IDLE;
            pc    <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (state == S_WRITEBACK)
                pc <= next_pc;
        end
    end

    always_comb
    begin
        case (state)
            S_IDLE:      state_nxt = start ? S_FETCH : S_IDLE;
            S_FETCH:     state_nxt = S_DECODE;
            S_DECODE:    state_nxt = S_EXECUTE;
            // Only LW and SW take the extra memory cycle
            S_EXECUTE:   state_nxt = (is_lw || is_sw) ? S_MEM : S_WRITEBACK;
            S_MEM:       state_nxt = S_WRITEBACK;
            S_WRITEBACK: state_nxt = is_halt ? S_HALT : S_FETCH;
            S_HALT:      state_nxt = S_HALT;
            default:     state_nxt = S_IDLE;
        endcase
    end

    // Capture instruction and operands, then the ALU output
    always_ff @(posedge i_clk)
    begin
        if (state == S_DECODE)
        begin
            ir     <= imem_instr;
            rs_val <= rf.rs_data;
            rt_val <= rf.rt_data;
        end
        if (state == S_EXECUTE)
        begin
            alu_out <= alu_result;
            zero_q  <= alu_zero;
        end
    end

    //////////////////////////////
    // Decode
    //////////////////////////////
    always_comb
    begin
        writes_reg = 1'b0;
        use_imm    = 1'b1;
        imm_zext   = 1'b0;
        is_lw      = 1'b0;
        is_sw      = 1'b0;
        is_beq     = 1'b0;
        is_halt    = 1'b0;
        alu_op     = ALU_ADD;
        case (ir.r.opcode)
            OP_RTYPE:
            begin
                use_imm    = 1'b0;
                writes_reg = 1'b1;
                case (ir.r.funct)
                    FN_ADD:          alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_NOR:          alu_op = ALU_NOR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_SLT:          alu_op = ALU_SLT;
                    FN_SLL:          alu_op = ALU_SLL;
                    // Unknown funct, retire without a write
                    default:         writes_reg = 1'b0;
                endcase
            end
            OP_ADDI: writes_reg = 1'b1;
            OP_ORI:
            begin
                writes_reg = 1'b1;
                imm_zext   = 1'b1;
                alu_op     = ALU_OR;
            end
            OP_SLTI:
            begin
                writes_reg = 1'b1;
                alu_op     = ALU_SLT;
            end
            OP_LW:
            begin
                writes_reg = 1'b1;
                is_lw      = 1'b1;
            end
            OP_SW:   is_sw = 1'b1;
            // Compare rs and rt through a subtract
            OP_BEQ:
            begin
                use_imm = 1'b0;
                is_beq  = 1'b1;
                alu_op  = ALU_SUB;
            end
            OP_HALT: is_halt = 1'b1;
            default: writes_reg = 1'b0;
        endcase
    end

    // rd for R-type, rt otherwise
    assign dest    = (ir.r.opcode == OP_RTYPE) ? ir.r.rd : ir.i.rt;
    assign imm_ext = imm_zext ? {{(XLEN-16){1'b0}}, ir.i.imm16}
                              : {{(XLEN-16){ir.i.imm16[15]}}, ir.i.imm16};

    // Branch offset counts words from PC+4
    assign pc_plus4 = pc + XLEN'(4);
    assign next_pc  = (is_beq && zero_q) ? pc_plus4 + {imm_ext[XLEN-3:0], 2'b00} : pc_plus4;
    assign wb_data  = is_lw ? dmem_rdata : alu_out;

    //////////////////////////////
    // Datapath drive
    //////////////////////////////
    assign imem_addr = pc[IMEM_AW+1:2];

    assign alu_a     = rs_val;
    assign alu_b     = use_imm ? imm_ext : rt_val;
    assign alu_shamt = ir.r.shamt;

    // Register addresses come straight from the fetched word in DECODE
    assign rf.rs_addr = imem_instr.r.rs;
    assign rf.rt_addr = imem_instr.r.rt;
    assign rf.wr_en   = (state == S_WRITEBACK) && writes_reg;
    assign rf.wr_addr = dest;
    assign rf.wr_data = wb_data;

    // Address holds through WRITEBACK so LW data lands there
    assign dmem_addr  = alu_out[DMEM_AW+1:2];
    assign dmem_wdata = rt_val;
    assign dmem_we    = (state == S_MEM) && is_sw;

    //////////////////////////////
    // Retire report
    //////////////////////////////
    assign retire    = (state == S_WRITEBACK);
    assign retire_pc = pc;
    assign retire_we = rf.wr_en;

    always_comb
    begin
        retire_waddr = '0;
        retire_wdata = '0;
        if (is_sw)
        begin
            // Store reports word address and value, we stays low
            retire_waddr = {2'b00, alu_out[XLEN-1:2]};
            retire_wdata = rt_val;
        end
        else if (is_beq)
            retire_wdata = next_pc;
        else if (writes_reg)
        begin
            retire_waddr = XLEN'(dest);
            retire_wdata = wb_data;
        end
    end

    assign halted = (state == S_HALT);
    assign idle   = (state == S_IDLE);

endmodule

`default_nettype wire

/* hw/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem import mips_pkg::*; #(
    parameter int  DMEM_WORDS = 64,
    localparam int DMEM_AW    = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1
) (
    input  logic               i_clk,
    // Word index, not byte address
    input  logic [DMEM_AW-1:0] addr,
    input  logic [XLEN-1:0]    wdata,
    input  logic               we,
    output logic [XLEN-1:0]    rdata
);

    logic [XLEN-1:0] mem [DMEM_WORDS];

    // Contents start cleared
    initial
    begin
        for (int i = 0; i < DMEM_WORDS; i++)
            mem[i] = '0;
    end

    //////////////////////////////
    // Write and registered read
    //////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (we)
            mem[addr] <= wdata;
        // Read returns the old word on a same-cycle write
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* hw/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_mem import mips_pkg::*; #(
    parameter int  IMEM_WORDS = 64,
    localparam int IMEM_AW    = (IMEM_WORDS > 1) ? $clog2(IMEM_WORDS) : 1
) (
    input  logic               i_clk,
    // Fetch side, word index
    input  logic [IMEM_AW-1:0] addr,
    output instr_t             instr,
    // Program load side
    input  logic               wr_en,
    input  logic [IMEM_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]    wr_data
);

    // Program storage, one instruction per word
    instr_t mem [IMEM_WORDS];

    //////////////////////////////
    // Load port
    //////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (wr_en)
            mem[wr_addr] <= instr_t'(wr_data);
    end

    // Registered read, instruction shows up one cycle after addr
    always_ff @(posedge i_clk)
    begin
        instr <= mem[addr];
    end

endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // Datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    //////////////////////////////
    // Primary opcodes, bits 31:26
    //////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    // All ones stops the core
    localparam logic [5:0] OP_HALT  = 6'b111111;

    // R-type function field, bits 5:0
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    // SLL shares the all-zero funct, so a zero word is SLL r0, r0, 0
    localparam logic [5:0] FN_SLL  = 6'b000000;

    // Operations the ALU knows about
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL
    } alu_op_t;

    //////////////////////////////
    // Instruction word views
    //////////////////////////////
    // Register format
    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fields_t;

    // Immediate format, also loads, stores and branches
    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm16;
    } i_fields_t;

    // Same 32 bits, read either way
    typedef union packed {
        logic [XLEN-1:0] word;
        r_fields_t       r;
        i_fields_t       i;
    } instr_t;

endpackage

`default_nettype wire

/* hw/mips_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_top import mips_pkg::*; #(
    parameter int  IMEM_WORDS = 64,
    parameter int  DMEM_WORDS = 64,
    localparam int IMEM_AW    = (IMEM_WORDS > 1) ? $clog2(IMEM_WORDS) : 1,
    localparam int DMEM_AW    = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1
) (
    input  logic               i_clk,
    input  logic               rst,
    input  logic               start,
    // Program load, word index
    input  logic               prog_we,
    input  logic [IMEM_AW-1:0] prog_addr,
    input  logic [XLEN-1:0]    prog_data,
    // Retire report
    output logic               retire,
    output logic [XLEN-1:0]    retire_pc,
    output logic               retire_we,
    output logic [XLEN-1:0]    retire_waddr,
    output logic [XLEN-1:0]    retire_wdata,
    output logic               halted
);

    logic [IMEM_AW-1:0] imem_addr;
    instr_t             imem_instr;
    logic [DMEM_AW-1:0] dmem_addr;
    logic [XLEN-1:0]    dmem_wdata, dmem_rdata;
    logic               dmem_we;
    logic [XLEN-1:0]    alu_a, alu_b, alu_result;
    logic [4:0]         alu_shamt;
    alu_op_t            alu_op;
    logic               alu_zero;
    logic               core_idle;
    logic               imem_we;

    regfile_if rf_bus ();

    // Program writes only land while the core sits in IDLE
    assign imem_we = prog_we && core_idle;

    //////////////////////////////
    // Memories
    //////////////////////////////
    instr_mem #(.IMEM_WORDS(IMEM_WORDS)) u_imem (
        .i_clk(i_clk), .addr(imem_addr), .instr(imem_instr),
        .wr_en(imem_we), .wr_addr(prog_addr), .wr_data(prog_data)
    );

    data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_dmem (
        .i_clk(i_clk), .addr(dmem_addr), .wdata(dmem_wdata),
        .we(dmem_we), .rdata(dmem_rdata)
    );

    //////////////////////////////
    // Core
    //////////////////////////////
    reg_file u_regs (.i_clk(i_clk), .rst(rst), .rf(rf_bus.regs));

    alu u_alu (
        .a(alu_a), .b(alu_b), .shamt(alu_shamt), .op(alu_op),
        .result(alu_result), .zero(alu_zero)
    );

    core_ctrl #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) u_ctrl (
        .i_clk(i_clk), .rst(rst), .start(start),
        .imem_addr(imem_addr), .imem_instr(imem_instr),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata),
        .alu_a(alu_a), .alu_b(alu_b), .alu_shamt(alu_shamt), .alu_op(alu_op),
        .alu_result(alu_result), .alu_zero(alu_zero),
        .rf(rf_bus.ctrl),
        .retire(retire), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_waddr(retire_waddr), .retire_wdata(retire_wdata),
        .halted(halted), .idle(core_idle)
    );

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import mips_pkg::*; (
    input  logic    i_clk,
    input  logic    rst,
    regfile_if.regs rf
);

    localparam int NREGS = 1 << REG_ADDR_W;

    // r0 is an ordinary register here
    logic [XLEN-1:0] regs [NREGS];

    //////////////////////////////
    // Write port
    //////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (rst)
        begin
            // Whole file clears
            for (int i = 0; i < NREGS; i++)
                regs[i] <= '0;
        end
        else if (rf.wr_en)
        begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////
    // Asynchronous, no bypass from the write port
    assign rf.rs_data = regs[rf.rs_addr];
    assign rf.rt_data = regs[rf.rt_addr];

endmodule

`default_nettype wire

/* hw/regfile_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface regfile_if import mips_pkg::*; ();

    // Two read ports
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;

    // Single write port, taken on the clock edge
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;

    // Control side drives addresses and writes
    modport ctrl (
        output rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        input  rs_data, rt_data
    );

    // Register side answers the reads
    modport regs (
        input  rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        output rs_data, rt_data
    );

endinterface

`default_nettype wire

/* list.f */
hw/mips_pkg.sv
hw/regfile_if.sv
hw/instr_mem.sv
hw/data_mem.sv
hw/reg_file.sv
hw/alu.sv
hw/core_ctrl.sv
hw/mips_top.sv
testbench/mips_assertions.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* testbench/mips_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_assertions import mips_pkg::*; (
    input logic       i_clk,
    input logic       rst,
    input logic       retire,
    input logic       retire_we,
    input logic       halted,
    input logic       dmem_we,
    input logic [5:0] opcode
);

    // Count of failed assertions over the whole run
    int failures = 0;

    // One WRITEBACK per instruction and never back to back
    a_retire_single : assert property (@(posedge i_clk) disable iff (rst)
        retire |=> !retire)
        else
        begin
            $error("retire high for two cycles in a row");
            failures++;
        end

    // Halted holds until reset
    a_halt_sticky : assert property (@(posedge i_clk) disable iff (rst)
        halted |=> halted)
        else
        begin
            $error("halted fell without reset");
            failures++;
        end

    // A store writes in its MEM cycle and retires the next cycle with no register write
    a_store_window : assert property (@(posedge i_clk) disable iff (rst)
        dmem_we |-> (opcode == OP_SW) ##1 (retire && !retire_we))
        else
        begin
            $error("data memory write outside MEM of a store");
            failures++;
        end

endmodule

bind core_ctrl mips_assertions u_assert (
    .i_clk(i_clk), .rst(rst), .retire(retire), .retire_we(retire_we),
    .halted(halted), .dmem_we(dmem_we), .opcode(ir.r.opcode)
);

`default_nettype wire

/* testbench/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import mips_pkg::*; (
    input logic            i_clk,
    input logic            rst,
    input logic            start,
    input logic            prog_we,
    input logic [5:0]      prog_addr,
    input logic [XLEN-1:0] prog_data,
    input logic            retire,
    input logic [XLEN-1:0] retire_pc,
    input logic            retire_we,
    input logic [XLEN-1:0] retire_waddr,
    input logic [XLEN-1:0] retire_wdata,
    input logic            halted
);

    // Model state
    // Data memory survives reset like the DUT's
    logic [XLEN-1:0] regs_m [32];
    logic [XLEN-1:0] dmem_m [64];
    logic [XLEN-1:0] imem_m [64];
    logic [XLEN-1:0] pc_m;
    logic            exp_we;
    logic [XLEN-1:0] exp_waddr, exp_wdata;
    bit              started;
    string           test_name;
    int              checks, errors, test_errors, retired, tests;

    initial
    begin
        foreach (dmem_m[k])
            dmem_m[k] = '0;
        foreach (imem_m[k])
            imem_m[k] = '0;
        checks = 0;
        errors = 0;
        tests  = 0;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    // Executes the instruction at pc_m and sets the expected retire fields
    function automatic void ref_step();
        instr_t          ins;
        logic [XLEN-1:0] a, b, simm, zimm, addr, res, npc;
        logic [4:0]      dst;
        logic            wr;
        ins  = instr_t'(imem_m[pc_m[7:2]]);
        a    = regs_m[ins.r.rs];
        b    = regs_m[ins.r.rt];
        simm = {{16{ins.i.imm16[15]}}, ins.i.imm16};
        zimm = {16'h0000, ins.i.imm16};
        npc  = pc_m + 32'd4;
        dst  = (ins.r.opcode == OP_RTYPE) ? ins.r.rd : ins.i.rt;
        wr   = 1'b0;
        res  = '0;
        addr = a + simm;
        exp_waddr = '0;
        exp_wdata = '0;
        case (ins.r.opcode)
            OP_RTYPE:
            begin
                wr = 1'b1;
                case (ins.r.funct)
                    FN_ADD:          res = a + b;
                    FN_SUB, FN_SUBU: res = a - b;
                    FN_AND:          res = a & b;
                    FN_OR:           res = a | b;
                    FN_NOR:          res = ~(a | b);
                    FN_XOR:          res = a ^ b;
                    FN_SLT:          res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:          res = b << ins.r.shamt;
                    default:         wr = 1'b0;
                endcase
            end
            OP_ADDI:
            begin
                wr  = 1'b1;
                res = a + simm;
            end
            OP_ORI:
            begin
                wr  = 1'b1;
                res = a | zimm;
            end
            OP_SLTI:
            begin
                wr  = 1'b1;
                res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            end
            OP_LW:
            begin
                wr  = 1'b1;
                res = dmem_m[addr[7:2]];
            end
            OP_SW:
            begin
                dmem_m[addr[7:2]] = b;
                exp_waddr = addr >> 2;
                exp_wdata = b;
            end
            // Word offset counted from the next instruction
            OP_BEQ:
            begin
                if (a == b)
                    npc = npc + {simm[29:0], 2'b00};
                exp_wdata = npc;
            end
            default: ;
        endcase
        exp_we = wr;
        if (wr)
        begin
            regs_m[dst] = res;
            exp_waddr   = {27'd0, dst};
            exp_wdata   = res;
        end
        pc_m = npc;
    endfunction

    //////////////////////////////
    // Reporting
    //////////////////////////////
    task automatic report_failure(input string what);
        errors++;
        test_errors++;
        $display("Test %s: %s", test_name, what);
    endtask

    task automatic check_val(input string field, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            test_errors++;
            $display("Error %s: %s at pc %h expected %h actual %h",
                     test_name, field, retire_pc, exp, act);
        end
    endtask

    // Fresh model registers and PC as after a DUT reset
    task automatic begin_test(input string name);
        test_name   = name;
        foreach (regs_m[k])
            regs_m[k] = '0;
        pc_m        = '0;
        started     = 1'b0;
        test_errors = 0;
        retired     = 0;
    endtask

    task automatic end_test();
        if (!halted)
            report_failure("halted is not high at the end of the test");
        tests++;
        $display("Test %s: %0d retired, %0d errors", test_name, retired, test_errors);
    endtask

    task automatic print_summary(input int assert_failures);
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, assert_failures);
    endtask

    //////////////////////////////
    // Compare process
    //////////////////////////////
    always @(posedge i_clk)
    begin
        if (!rst)
        begin
            // Mirror the program as it is written
            if (prog_we)
                imem_m[prog_addr] = prog_data;
            if (!started && (retire || halted))
                report_failure("retire or halted seen before start");
            if (start)
                started = 1'b1;
            if (halted && retire)
                report_failure("retire pulsed while halted");
            if (retire)
            begin
                retired++;
                check_val("pc", pc_m, retire_pc);
                ref_step();
                check_val("we", {31'd0, exp_we}, {31'd0, retire_we});
                check_val("waddr", exp_waddr, retire_waddr);
                check_val("wdata", exp_wdata, retire_wdata);
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top import mips_pkg::*; ();

    logic            i_clk;
    logic            rst;
    logic            start;
    logic            prog_we;
    logic [5:0]      prog_addr;
    logic [XLEN-1:0] prog_data;
    logic            retire, retire_we, halted;
    logic [XLEN-1:0] retire_pc, retire_waddr, retire_wdata;

    // Program under construction and watchdog state
    logic [XLEN-1:0] prog [$];
    string           cur_name;
    int              budget, cycles;
    bit              running;

    mips_top dut (
        .i_clk(i_clk), .rst(rst), .start(start),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .retire(retire), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_waddr(retire_waddr), .retire_wdata(retire_wdata), .halted(halted)
    );

    tb_checker u_chk (
        .i_clk(i_clk), .rst(rst), .start(start),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .retire(retire), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_waddr(retire_waddr), .retire_wdata(retire_wdata), .halted(halted)
    );

    // 4 ns clock
    initial
        i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    //////////////////////////////
    // Watchdog
    //////////////////////////////
    // Budget is 6 cycles per program word plus reset and idle margin
    always @(posedge i_clk)
    begin
        if (running)
        begin
            cycles++;
            if (cycles > budget)
            begin
                $display("Timeout: test %s did not halt within %0d cycles", cur_name, budget);
                $display("Checks failed");
                $finish;
            end
        end
    end

    //////////////////////////////
    // Encoders
    //////////////////////////////
    function automatic logic [31:0] enc_r(input logic [5:0] fn, input int rd,
                                          input int rs, input int rt, input int sh);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input int rt,
                                          input int rs, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // Reset, load, start, wait for halt, then watch it stay halted
    task automatic run_test(input string name);
        cur_name = name;
        cycles   = 0;
        budget   = 6 * prog.size() + 40;
        running  = 1'b1;
        @(posedge i_clk);
        rst <= 1'b1;
        repeat (3) @(posedge i_clk);
        // Model restarts while the DUT is still held in reset
        u_chk.begin_test(name);
        rst <= 1'b0;
        foreach (prog[k])
        begin
            @(posedge i_clk);
            prog_we   <= 1'b1;
            prog_addr <= k[5:0];
            prog_data <= prog[k];
        end
        @(posedge i_clk);
        prog_we <= 1'b0;
        // Idle stretch where nothing should retire yet
        repeat (4) @(posedge i_clk);
        start <= 1'b1;
        @(posedge i_clk);
        start <= 1'b0;
        while (!halted)
            @(posedge i_clk);
        repeat (6) @(posedge i_clk);
        running = 1'b0;
        u_chk.end_test();
        prog.delete();
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial
    begin
        logic [31:0] v;
        int          a;
        logic [5:0]  fns [9];
        fns = '{FN_ADD, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_NOR, FN_XOR, FN_SLT, FN_SLL};
        void'($urandom(15));
        rst       = 1'b1;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        running   = 1'b0;

        // Reference program with register setup in front
        // BEQ at 36 lands on 52
        prog.push_back(enc_i(OP_ORI, 1, 0, 16'h1234));
        prog.push_back(enc_i(OP_ADDI, 2, 0, -7));
        prog.push_back(enc_r(FN_SUBU, 3, 1, 2, 0));
        prog.push_back(enc_r(FN_ADD, 4, 1, 2, 0));
        prog.push_back(enc_r(FN_AND, 5, 1, 2, 0));
        prog.push_back(enc_r(FN_OR, 6, 1, 2, 0));
        prog.push_back(enc_r(FN_SLT, 7, 2, 1, 0));
        prog.push_back(enc_i(OP_LW, 8, 0, 4));
        prog.push_back(enc_i(OP_SW, 3, 0, 12));
        prog.push_back(enc_i(OP_BEQ, 0, 0, 3));
        repeat (3) prog.push_back(enc_r(FN_ADD, 10, 1, 1, 0));
        prog.push_back(enc_r(FN_ADD, 9, 3, 4, 0));
        prog.push_back({OP_HALT, 26'd0});
        run_test("reference_program");

        // Random full-width registers built from ORI, SLL, ORI
        for (int r = 1; r <= 6; r++)
        begin
            v = $urandom;
            prog.push_back(enc_i(OP_ORI, r, 0, v[31:16]));
            prog.push_back(enc_r(FN_SLL, r, 0, r, 16));
            prog.push_back(enc_i(OP_ORI, r, r, v[15:0]));
        end
        for (int k = 0; k < 18; k++)
            prog.push_back(enc_r(fns[k % 9], 1 + $urandom % 6, 1 + $urandom % 6,
                                 1 + $urandom % 6, $urandom % 32));
        prog.push_back({OP_HALT, 26'd0});
        run_test("random_rtype");

        // Immediates around the sign boundary
        prog.push_back(enc_i(OP_ORI, 1, 0, 16'h8000));
        prog.push_back(enc_i(OP_ADDI, 2, 0, 16'h8000));
        prog.push_back(enc_i(OP_ADDI, 3, 0, 16'h7fff));
        prog.push_back(enc_i(OP_SLTI, 4, 0, 16'h8000));
        prog.push_back(enc_i(OP_SLTI, 5, 2, 16'h8001));
        prog.push_back(enc_i(OP_ORI, 6, 2, 16'hffff));
        prog.push_back(enc_i(OP_ADDI, 7, 1, 16'h8001));
        prog.push_back({OP_HALT, 26'd0});
        run_test("immediates");

        // Store then load back at random word addresses
        for (int k = 0; k < 4; k++)
        begin
            a = $urandom % 64;
            v = $urandom | 32'd1;
            prog.push_back(enc_i(OP_ORI, 1, 0, v[15:0]));
            prog.push_back(enc_i(OP_SW, 1, 0, a * 4));
            prog.push_back(enc_i(OP_LW, k + 2, 0, a * 4));
        end
        // r1 is odd, so this branch falls through
        prog.push_back(enc_i(OP_BEQ, 0, 1, 1));
        prog.push_back(enc_i(OP_ADDI, 7, 0, 5));
        prog.push_back({OP_HALT, 26'd0});
        run_test("store_load_branch");

        prog.push_back({OP_HALT, 26'd0});
        run_test("halt_only");

        u_chk.print_summary(dut.u_ctrl.u_assert.failures);
        if (u_chk.errors == 0 && dut.u_ctrl.u_assert.failures == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
